/* include/rob_params.svh */
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Log2 of bank count, also the issue and commit width
`define ROB_P_BANKS 1
// Log2 of entries per bank
`define ROB_P_DEPTH 3

`define ROB_BANKS (1 << `ROB_P_BANKS)
`define ROB_DEPTH (1 << `ROB_P_DEPTH)

`define ROB_WB_PORTS 2

// Field widths
`define ROB_PC_W 32
`define ROB_DW 32
`define ROB_LRF_AW 5
`define ROB_PRF_AW 6

`endif

/* hw/rob_pkg.sv */
`include "rob_params.svh"

package rob_pkg;

   // Dispatch payload
   typedef struct packed {
      logic [`ROB_PC_W-1:0]   pc;
      logic [`ROB_LRF_AW-1:0] lrd;
      logic [`ROB_PRF_AW-1:0] prd;
      logic                   prd_we;
      logic [`ROB_PRF_AW-1:0] pfree;
   } rob_uop_t;

   typedef struct packed {
      logic [`ROB_DW-1:0]   value;
      logic [`ROB_PC_W-1:0] fls_tgt;
   } rob_result_t;

   // Entry address
   typedef struct packed {
      logic [`ROB_P_BANKS-1:0] bank;
      logic [`ROB_P_DEPTH-1:0] id;
   } rob_slot_t;

   typedef struct packed {
      logic        valid;
      rob_slot_t   slot;
      logic        fls;
      logic        exc;
      rob_result_t result;
   } rob_wb_t;

   typedef struct packed {
      rob_uop_t    uop;
      logic        fls;
      logic        exc;
      rob_result_t result;
   } rob_cmt_t;

   // Completion state seen at a bank's read pointer
   typedef struct packed {
      logic        rdy;
      logic        fls;
      logic        exc;
      rob_result_t result;
   } rob_tag_t;

endpackage

/* hw/rob_bank_ram.sv */
module rob_bank_ram
#(
   parameter type entry_t = logic [7:0],
   parameter int  DEPTH_W = 3
)
(
   input  logic               clk,
   input  logic               we,
   input  logic [DEPTH_W-1:0] waddr,
   input  entry_t             wdata,
   input  logic [DEPTH_W-1:0] raddr,
   output entry_t             rdata
);

   entry_t mem [1 << DEPTH_W];

   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // Asynchronous read
   assign rdata = mem[raddr];

endmodule

/* hw/rob_dispatch.sv */
`include "rob_params.svh"

module rob_dispatch
(
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    flush,
   input  logic [`ROB_P_BANKS:0]   push_size,
   input  rob_pkg::rob_uop_t       push_uop [`ROB_BANKS],
   input  logic [`ROB_BANKS-1:0]   pop,
   output logic                    ready,
   output rob_pkg::rob_slot_t      free_slot [`ROB_BANKS],
   output logic [`ROB_BANKS-1:0]   bank_push,
   output logic [`ROB_P_DEPTH-1:0] wptr [`ROB_BANKS],
   output logic [`ROB_P_DEPTH-1:0] rptr [`ROB_BANKS],
   output rob_pkg::rob_uop_t       head_uop [`ROB_BANKS],
   output logic [`ROB_BANKS-1:0]   bank_valid
);

   localparam int P_BANKS = `ROB_P_BANKS;
   localparam int BANKS   = `ROB_BANKS;
   localparam int DEPTH_W = `ROB_P_DEPTH;

   logic [P_BANKS-1:0] tail_q;
   logic [BANKS-1:0]   bank_full;

   // Issue slot k goes to bank tail+k
   for (genvar k = 0; k < BANKS; k++)
   begin : g_slot
      logic [P_BANKS-1:0] dst;

      assign dst = tail_q + P_BANKS'(k);
      assign free_slot[k].bank = dst;
      assign free_slot[k].id = wptr[dst];
   end

   for (genvar b = 0; b < BANKS; b++)
   begin : g_bank
      logic [P_BANKS-1:0] src;
      logic [DEPTH_W:0]   wp_q;
      logic [DEPTH_W:0]   rp_q;

      // Issue slot feeding this bank
      assign src = P_BANKS'(b) - tail_q;
      assign bank_push[b] = ready & ~flush & ({1'b0, src} < push_size);

      // Same index, different wrap bit
      assign bank_full[b] = (wp_q ^ rp_q) == {1'b1, {DEPTH_W{1'b0}}};
      assign bank_valid[b] = wp_q != rp_q;
      assign wptr[b] = wp_q[DEPTH_W-1:0];
      assign rptr[b] = rp_q[DEPTH_W-1:0];

      always_ff @(posedge clk or negedge arst_n)
      begin
         if (!arst_n)
         begin
            wp_q <= '0;
            rp_q <= '0;
         end
         else if (flush)
         begin
            wp_q <= '0;
            rp_q <= '0;
         end
         else
         begin
            if (bank_push[b])
            begin
               wp_q <= wp_q + 1'b1;
            end
            if (pop[b])
            begin
               rp_q <= rp_q + 1'b1;
            end
         end
      end

      rob_bank_ram
      #(
         .entry_t (rob_pkg::rob_uop_t),
         .DEPTH_W (DEPTH_W)
      )
      u_uop_ram
      (
         .clk   (clk),
         .we    (bank_push[b]),
         .waddr (wptr[b]),
         .wdata (push_uop[src]),
         .raddr (rptr[b]),
         .rdata (head_uop[b])
      );
   end

   assign ready = ~|bank_full;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tail_q <= '0;
      end
      else if (flush)
      begin
         tail_q <= '0;
      end
      else if (ready)
      begin
         tail_q <= tail_q + push_size[P_BANKS-1:0];
      end
   end

endmodule

/* hw/rob_complete.sv */
`include "rob_params.svh"

module rob_complete
(
   input  logic                    clk,
   input  logic                    arst_n,
   input  rob_pkg::rob_wb_t        wb [`ROB_WB_PORTS],
   input  logic [`ROB_BANKS-1:0]   bank_push,
   input  logic [`ROB_P_DEPTH-1:0] wptr [`ROB_BANKS],
   input  logic [`ROB_P_DEPTH-1:0] rptr [`ROB_BANKS],
   output rob_pkg::rob_tag_t       tag [`ROB_BANKS]
);

   localparam int P_BANKS  = `ROB_P_BANKS;
   localparam int BANKS    = `ROB_BANKS;
   localparam int DEPTH    = `ROB_DEPTH;
   localparam int WB_PORTS = `ROB_WB_PORTS;

   for (genvar b = 0; b < BANKS; b++)
   begin : g_bank
      rob_pkg::rob_wb_t     bank_wb;
      rob_pkg::rob_result_t res_rd;
      logic [DEPTH-1:0]     rdy_q;
      logic [DEPTH-1:0]     fls_q;
      logic [DEPTH-1:0]     exc_q;

      // One writeback per bank per cycle, lowest port wins a clash
      always_comb
      begin
         bank_wb = '0;
         for (int p = WB_PORTS - 1; p >= 0; p--)
         begin
            if (wb[p].valid && wb[p].slot.bank == P_BANKS'(b))
            begin
               bank_wb = wb[p];
            end
         end
      end

      always_ff @(posedge clk or negedge arst_n)
      begin
         if (!arst_n)
         begin
            rdy_q <= '0;
            fls_q <= '0;
            exc_q <= '0;
         end
         else
         begin
            if (bank_wb.valid)
            begin
               rdy_q[bank_wb.slot.id] <= 1'b1;
               fls_q[bank_wb.slot.id] <= bank_wb.fls;
               exc_q[bank_wb.slot.id] <= bank_wb.exc;
            end
            // Push clears its entry, last so it beats a writeback
            if (bank_push[b])
            begin
               rdy_q[wptr[b]] <= 1'b0;
               fls_q[wptr[b]] <= 1'b0;
               exc_q[wptr[b]] <= 1'b0;
            end
         end
      end

      rob_bank_ram
      #(
         .entry_t (rob_pkg::rob_result_t),
         .DEPTH_W (`ROB_P_DEPTH)
      )
      u_res_ram
      (
         .clk   (clk),
         .we    (bank_wb.valid),
         .waddr (bank_wb.slot.id),
         .wdata (bank_wb.result),
         .raddr (rptr[b]),
         .rdata (res_rd)
      );

      assign tag[b] = '{rdy: rdy_q[rptr[b]], fls: fls_q[rptr[b]],
                        exc: exc_q[rptr[b]], result: res_rd};
   end

endmodule

/* hw/rob_commit.sv */
`include "rob_params.svh"

module rob_commit
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  flush,
   input  logic [`ROB_P_BANKS:0] pop_size,
   input  rob_pkg::rob_uop_t     head_uop [`ROB_BANKS],
   input  logic [`ROB_BANKS-1:0] bank_valid,
   input  rob_pkg::rob_tag_t     tag [`ROB_BANKS],
   output logic [`ROB_BANKS-1:0] pop,
   output logic [`ROB_BANKS-1:0] cmt_valid,
   output rob_pkg::rob_cmt_t     cmt [`ROB_BANKS]
);

   localparam int P_BANKS = `ROB_P_BANKS;
   localparam int BANKS   = `ROB_BANKS;

   logic [P_BANKS-1:0] head_q;
   logic [BANKS-1:0]   ent_valid;

   // Commit slot k reads bank head+k
   for (genvar k = 0; k < BANKS; k++)
   begin : g_slot
      logic [P_BANKS-1:0] src;

      assign src = head_q + P_BANKS'(k);
      assign cmt[k] = '{uop: head_uop[src], fls: tag[src].fls,
                        exc: tag[src].exc, result: tag[src].result};
      assign ent_valid[k] = bank_valid[src] & tag[src].rdy;
   end

   for (genvar b = 0; b < BANKS; b++)
   begin : g_pop
      logic [P_BANKS-1:0] age;

      assign age = P_BANKS'(b) - head_q;
      assign pop[b] = {1'b0, age} < pop_size;
   end

   // Younger slots only valid behind valid older ones
   always_comb
   begin
      cmt_valid[0] = ent_valid[0];
      for (int j = 1; j < BANKS; j++)
      begin
         cmt_valid[j] = cmt_valid[j-1] & ent_valid[j];
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         head_q <= '0;
      end
      else if (flush)
      begin
         head_q <= '0;
      end
      else
      begin
         head_q <= head_q + pop_size[P_BANKS-1:0];
      end
   end

endmodule

/* hw/rob.sv */
`include "rob_params.svh"

module rob
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  flush,
   // Issue
   input  logic [`ROB_P_BANKS:0] push_size,
   input  rob_pkg::rob_uop_t     push_uop [`ROB_BANKS],
   output logic                  rob_ready,
   output rob_pkg::rob_slot_t    free_slot [`ROB_BANKS],
   // Writeback
   input  rob_pkg::rob_wb_t      wb [`ROB_WB_PORTS],
   // Commit
   output logic [`ROB_BANKS-1:0] cmt_valid,
   output rob_pkg::rob_cmt_t     cmt [`ROB_BANKS],
   input  logic [`ROB_P_BANKS:0] pop_size
);

   logic [`ROB_BANKS-1:0]   bank_push;
   logic [`ROB_BANKS-1:0]   bank_valid;
   logic [`ROB_BANKS-1:0]   pop;
   logic [`ROB_P_DEPTH-1:0] wptr [`ROB_BANKS];
   logic [`ROB_P_DEPTH-1:0] rptr [`ROB_BANKS];
   rob_pkg::rob_uop_t       head_uop [`ROB_BANKS];
   rob_pkg::rob_tag_t       tag [`ROB_BANKS];

   rob_dispatch u_dispatch
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .flush      (flush),
      .push_size  (push_size),
      .push_uop   (push_uop),
      .pop        (pop),
      .ready      (rob_ready),
      .free_slot  (free_slot),
      .bank_push  (bank_push),
      .wptr       (wptr),
      .rptr       (rptr),
      .head_uop   (head_uop),
      .bank_valid (bank_valid)
   );

   rob_complete u_complete
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .wb        (wb),
      .bank_push (bank_push),
      .wptr      (wptr),
      .rptr      (rptr),
      .tag       (tag)
   );

   rob_commit u_commit
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .flush      (flush),
      .pop_size   (pop_size),
      .head_uop   (head_uop),
      .bank_valid (bank_valid),
      .tag        (tag),
      .pop        (pop),
      .cmt_valid  (cmt_valid),
      .cmt        (cmt)
   );

endmodule

/* dv/rob_properties.sv */
`include "rob_params.svh"

module rob_properties
(
   input logic                  clk,
   input logic                  arst_n,
   input logic                  rob_ready,
   input logic [`ROB_P_BANKS:0] push_size,
   input logic [`ROB_BANKS-1:0] cmt_valid,
   input logic [`ROB_P_BANKS:0] pop_size
);

   logic [`ROB_P_BANKS:0] lead;

   // Leading run of valid commit slots, two wide
   assign lead = cmt_valid[1] ? 2'd2 : {1'b0, cmt_valid[0]};

   push_needs_ready: assert property (@(posedge clk) disable iff (!arst_n)
      (push_size != '0) |-> rob_ready)
      else $error("push presented while rob_ready is low");

   valid_in_order: assert property (@(posedge clk) disable iff (!arst_n)
      cmt_valid[1] |-> cmt_valid[0])
      else $error("cmt_valid[1] high without cmt_valid[0]");

   pop_within_lead: assert property (@(posedge clk) disable iff (!arst_n)
      pop_size <= lead)
      else $error("pop_size beyond the leading valid commit slots");

endmodule

bind rob rob_properties u_properties
(
   .clk       (clk),
   .arst_n    (arst_n),
   .rob_ready (rob_ready),
   .push_size (push_size),
   .cmt_valid (cmt_valid),
   .pop_size  (pop_size)
);

/* dv/rob_checker.sv */
`include "rob_params.svh"

module rob_checker
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  flush,
   input  logic [`ROB_P_BANKS:0] push_size,
   input  rob_pkg::rob_uop_t     push_uop [`ROB_BANKS],
   input  logic                  rob_ready,
   input  rob_pkg::rob_slot_t    free_slot [`ROB_BANKS],
   input  rob_pkg::rob_wb_t      wb [`ROB_WB_PORTS],
   input  logic [`ROB_BANKS-1:0] cmt_valid,
   input  rob_pkg::rob_cmt_t     cmt [`ROB_BANKS],
   input  logic [`ROB_P_BANKS:0] pop_size,
   input  logic                  test_end,
   input  int                    test_id,
   input  logic                  report,
   output int                    error_count
);

   localparam int BANKS     = `ROB_BANKS;
   localparam int DEPTH     = `ROB_DEPTH;
   localparam int FILL_TEST = 3;

   // One in-flight instruction in program order
   typedef struct packed {
      rob_pkg::rob_slot_t slot;
      logic               done;
      rob_pkg::rob_cmt_t  exp;
   } inflight_t;

   inflight_t               q [$];
   logic [`ROB_P_BANKS-1:0] tail;
   logic [`ROB_P_DEPTH-1:0] wp [BANKS];
   int                      checks;
   int                      test_errors;
   int                      tests_run;
   int                      tests_failed;
   logic                    saw_full;
   logic                    saw_ready_again;

   function automatic string test_name(int id);
      case (id)
         1: return "reset_state";
         2: return "random_traffic";
         3: return "fill_and_drain";
         4: return "flush_recovery";
         default: return "unknown";
      endcase
   endfunction

   // Issue slot k lands in bank tail+k at that bank's write pointer
   function automatic rob_pkg::rob_slot_t next_slot(int k);
      rob_pkg::rob_slot_t s;
      s.bank = tail + `ROB_P_BANKS'(k);
      s.id = wp[s.bank];
      return s;
   endfunction

   function automatic logic model_ready();
      int cnt [BANKS];
      logic rdy;
      rdy = 1'b1;
      foreach (cnt[b])
      begin
         cnt[b] = 0;
      end
      foreach (q[i])
      begin
         cnt[q[i].slot.bank]++;
      end
      foreach (cnt[b])
      begin
         if (cnt[b] == DEPTH)
         begin
            rdy = 1'b0;
         end
      end
      return rdy;
   endfunction

   // Oldest entries present and written back in order
   function automatic int model_lead();
      int n;
      n = 0;
      while (n < BANKS && n < q.size() && q[n].done)
      begin
         n++;
      end
      return n;
   endfunction

   task automatic compare_value(input string name, input logic [127:0] exp_v,
                                input logic [127:0] got);
      checks++;
      if (exp_v !== got)
      begin
         $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp_v, got);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic report_failure(input string what);
      $display("Failure at t=%0t, %s", $time, what);
      error_count++;
      test_errors++;
   endtask

   // Buffer has to fill up and later accept pushes again
   task automatic track_fill();
      if (!model_ready())
      begin
         saw_full = 1'b1;
      end
      else if (saw_full)
      begin
         saw_ready_again = 1'b1;
      end
   endtask

   task automatic check_outputs();
      int lead;
      lead = model_lead();
      compare_value("rob_ready", 128'(model_ready()), 128'(rob_ready));
      for (int k = 0; k < BANKS; k++)
      begin
         compare_value($sformatf("free_slot[%0d]", k), 128'(next_slot(k)), 128'(free_slot[k]));
         compare_value($sformatf("cmt_valid[%0d]", k), 128'(k < lead), 128'(cmt_valid[k]));
         if (k < lead)
         begin
            compare_value($sformatf("cmt[%0d].uop", k), 128'(q[k].exp.uop), 128'(cmt[k].uop));
            compare_value($sformatf("cmt[%0d].fls", k), 128'(q[k].exp.fls), 128'(cmt[k].fls));
            compare_value($sformatf("cmt[%0d].exc", k), 128'(q[k].exp.exc), 128'(cmt[k].exc));
            compare_value($sformatf("cmt[%0d].result", k), 128'(q[k].exp.result),
                          128'(cmt[k].result));
         end
      end
   endtask

   task automatic update_model();
      logic      ready;
      int        lead;
      int        found;
      inflight_t e;
      ready = model_ready();
      lead = model_lead();
      for (int p = 0; p < `ROB_WB_PORTS; p++)
      begin
         if (wb[p].valid)
         begin
            found = 0;
            foreach (q[i])
            begin
               if (q[i].slot == wb[p].slot && !q[i].done)
               begin
                  e = q[i];
                  e.done = 1'b1;
                  e.exp.fls = wb[p].fls;
                  e.exp.exc = wb[p].exc;
                  e.exp.result = wb[p].result;
                  q[i] = e;
                  found = 1;
               end
            end
            if (found == 0)
            begin
               report_failure($sformatf("writeback port %0d names an entry not in flight", p));
            end
         end
      end
      if (int'(pop_size) > lead)
      begin
         report_failure("pop_size asks for more entries than are ready to commit");
      end
      for (int i = 0; i < int'(pop_size) && q.size() > 0; i++)
      begin
         void'(q.pop_front());
      end
      if (push_size != '0 && !ready)
      begin
         report_failure("a push was presented while the buffer was full");
      end
      else if (push_size != '0)
      begin
         for (int k = 0; k < int'(push_size); k++)
         begin
            e = '0;
            e.slot = next_slot(k);
            e.exp.uop = push_uop[k];
            q.push_back(e);
            wp[e.slot.bank] = wp[e.slot.bank] + `ROB_P_DEPTH'(1);
         end
         tail = tail + push_size[`ROB_P_BANKS-1:0];
      end
   endtask

   always @(posedge clk)
   begin
      if (!arst_n)
      begin
         q.delete();
         tail = '0;
         foreach (wp[b])
         begin
            wp[b] = '0;
         end
         error_count = 0;
         checks = 0;
         test_errors = 0;
         tests_run = 0;
         tests_failed = 0;
         saw_full = 1'b0;
         saw_ready_again = 1'b0;
      end
      else
      begin
         check_outputs();
         track_fill();
         if (flush)
         begin
            q.delete();
            tail = '0;
            foreach (wp[b])
            begin
               wp[b] = '0;
            end
            saw_full = 1'b0;
            saw_ready_again = 1'b0;
         end
         else
         begin
            update_model();
         end
         if (test_end)
         begin
            if (test_id == FILL_TEST && !(saw_full && saw_ready_again))
            begin
               report_failure("the buffer never filled up and then accepted pushes again");
            end
            tests_run++;
            if (test_errors != 0)
            begin
               tests_failed++;
            end
            $display("Test %0d %s: %s, %0d errors", test_id, test_name(test_id),
                     (test_errors == 0) ? "ok" : "failed", test_errors);
            test_errors = 0;
            saw_full = 1'b0;
            saw_ready_again = 1'b0;
         end
         if (report)
         begin
            $display("Totals: %0d tests, %0d failed, %0d checks, %0d errors",
                     tests_run, tests_failed, checks, error_count);
         end
      end
   end

endmodule

/* dv/rob_tb.sv */
`include "rob_params.svh"

module rob_tb;

   localparam int SZ_W       = `ROB_P_BANKS + 1;
   localparam int RESET_LEN  = 20;
   localparam int RANDOM_LEN = 1500;
   localparam int FILL_LEN   = 40;
   localparam int DRAIN_LEN  = 20;
   localparam int FLUSH_LEN  = 40;
   localparam int MAX_CYCLES =
      4 * (RESET_LEN + RANDOM_LEN + FILL_LEN + DRAIN_LEN + FLUSH_LEN) + 100;

   logic                  clk;
   logic                  arst_n;
   logic                  flush;
   logic [`ROB_P_BANKS:0] push_size;
   rob_pkg::rob_uop_t     push_uop [`ROB_BANKS];
   logic                  rob_ready;
   rob_pkg::rob_slot_t    free_slot [`ROB_BANKS];
   rob_pkg::rob_wb_t      wb [`ROB_WB_PORTS];
   logic [`ROB_BANKS-1:0] cmt_valid;
   rob_pkg::rob_cmt_t     cmt [`ROB_BANKS];
   logic [`ROB_P_BANKS:0] pop_size;
   logic                  test_end;
   int                    test_id;
   logic                  report;
   int                    error_count;
   int                    cycles = 0;
   logic [15:0]           lfsr;
   // Slots pushed in an earlier cycle and not yet written back
   rob_pkg::rob_slot_t    pending [$];

   rob u_rob
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .flush     (flush),
      .push_size (push_size),
      .push_uop  (push_uop),
      .rob_ready (rob_ready),
      .free_slot (free_slot),
      .wb        (wb),
      .cmt_valid (cmt_valid),
      .cmt       (cmt),
      .pop_size  (pop_size)
   );

   rob_checker u_checker
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .flush       (flush),
      .push_size   (push_size),
      .push_uop    (push_uop),
      .rob_ready   (rob_ready),
      .free_slot   (free_slot),
      .wb          (wb),
      .cmt_valid   (cmt_valid),
      .cmt         (cmt),
      .pop_size    (pop_size),
      .test_end    (test_end),
      .test_id     (test_id),
      .report      (report),
      .error_count (error_count)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #2 clk = ~clk;
      end
   end

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic idle_inputs();
      flush = 1'b0;
      push_size = '0;
      pop_size = '0;
      for (int k = 0; k < `ROB_BANKS; k++)
      begin
         push_uop[k] = '0;
      end
      for (int p = 0; p < `ROB_WB_PORTS; p++)
      begin
         wb[p] = '0;
      end
   endtask

   task automatic flush_cycle();
      @(negedge clk);
      idle_inputs();
      flush = 1'b1;
      pending.delete();
   endtask

   task automatic random_cycle(input logic do_pop, input int flush_rate);
      int idx;
      int lead;
      int n;
      idle_inputs();
      if (int'(rand_bits(6)) < flush_rate)
      begin
         flush = 1'b1;
         pending.delete();
      end
      else
      begin
         // Two ports never aim at the same bank
         for (int p = 0; p < `ROB_WB_PORTS; p++)
         begin
            if (pending.size() > 0 && rand_bits(1) == 32'd1)
            begin
               idx = int'(rand_bits(4)) % pending.size();
               if (p == 0 || !wb[0].valid || pending[idx].bank != wb[0].slot.bank)
               begin
                  wb[p].valid = 1'b1;
                  wb[p].slot = pending[idx];
                  wb[p].fls = 1'(rand_bits(1));
                  wb[p].exc = 1'(rand_bits(1));
                  wb[p].result.value = rand_bits(`ROB_DW);
                  wb[p].result.fls_tgt = rand_bits(`ROB_PC_W);
                  pending.delete(idx);
               end
            end
         end
         if (do_pop)
         begin
            lead = 0;
            while (lead < `ROB_BANKS && cmt_valid[lead])
            begin
               lead++;
            end
            pop_size = SZ_W'(int'(rand_bits(2)) % (lead + 1));
         end
         if (rob_ready)
         begin
            n = int'(rand_bits(2)) % (`ROB_BANKS + 1);
            push_size = SZ_W'(n);
            for (int k = 0; k < n; k++)
            begin
               push_uop[k].pc = rand_bits(`ROB_PC_W);
               push_uop[k].lrd = `ROB_LRF_AW'(rand_bits(`ROB_LRF_AW));
               push_uop[k].prd = `ROB_PRF_AW'(rand_bits(`ROB_PRF_AW));
               push_uop[k].prd_we = 1'(rand_bits(1));
               push_uop[k].pfree = `ROB_PRF_AW'(rand_bits(`ROB_PRF_AW));
               pending.push_back(free_slot[k]);
            end
         end
      end
   endtask

   task automatic run_random(input int len, input logic do_pop, input int flush_rate);
      repeat (len)
      begin
         @(negedge clk);
         random_cycle(do_pop, flush_rate);
      end
   endtask

   task automatic finish_test(input int id);
      @(negedge clk);
      idle_inputs();
      test_id = id;
      test_end = 1'b1;
      @(negedge clk);
      test_end = 1'b0;
   endtask

   initial
   begin
      lfsr = 16'd43828;
      arst_n = 1'b0;
      test_end = 1'b0;
      test_id = 0;
      report = 1'b0;
      idle_inputs();
      repeat (10) @(negedge clk);
      arst_n = 1'b1;

      repeat (RESET_LEN) @(negedge clk);
      finish_test(1);

      run_random(RANDOM_LEN, 1'b1, 1);
      finish_test(2);

      // No pops until well after the banks fill
      flush_cycle();
      run_random(FILL_LEN, 1'b0, 0);
      run_random(DRAIN_LEN, 1'b1, 0);
      finish_test(3);

      run_random(FLUSH_LEN / 2, 1'b1, 0);
      flush_cycle();
      run_random(FLUSH_LEN / 2, 1'b1, 0);
      finish_test(4);

      report = 1'b1;
      @(negedge clk);
      report = 1'b0;
      @(negedge clk);
      if (error_count == 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles, the run did not complete", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

endmodule

/* rob.f */
+incdir+include
hw/rob_pkg.sv
hw/rob_bank_ram.sv
hw/rob_dispatch.sv
hw/rob_complete.sv
hw/rob_commit.sv
hw/rob.sv
dv/rob_properties.sv
dv/rob_checker.sv
dv/rob_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f rob.f --top-module rob_tb --Mdir obj_dir
	./obj_dir/Vrob_tb +verilator+error+limit+100 | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
